/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbFetchTop
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ctiQueue.sv */
`timescale 1ns/1ps

module ctiQueue
  import fetchPkg::*;
(
  input  logic                       clk,
  input  logic                       rstN_i,
  input  logic     [FETCH_WIDTH-1:0] allocMask_i,
  input  pcT       [FETCH_WIDTH-1:0] allocPc_i,
  input  ctrlTypeE [FETCH_WIDTH-1:0] allocType_i,
  input  pcT       [FETCH_WIDTH-1:0] allocTarget_i,
  input  logic     [FETCH_WIDTH-1:0] allocDir_i,
  input  logic                       commitCti_i,
  output ctiTagT                     tailTag_o,
  output logic                       full_o,
  output logic                       updateValid_o,
  output updateS                     update_o
);

  updateS                   mem [CTIQ_DEPTH];
  ctiTagT                   head;
  ctiTagT                   tail;
  ctiCntT                   count;
  ctiTagT [FETCH_WIDTH-1:0] allocIdx;
  ctiCntT                   allocNum;

  // Allocated slots are packed into consecutive entries from the tail
  always_comb begin : allocSlots
    ctiTagT idx;
    idx      = tail;
    allocNum = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      allocIdx[i] = idx;
      if (allocMask_i[i]) begin
        idx      = idx + 1'b1;
        allocNum = allocNum + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (allocMask_i[i]) begin
        mem[allocIdx[i]] <= '{pc: allocPc_i[i], target: allocTarget_i[i],
                              ctrlType: allocType_i[i], dir: allocDir_i[i]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      updateValid_o <= 1'b0;
    end else begin
      tail          <= tail + ctiTagT'(allocNum);
      count         <= count + allocNum - ctiCntT'(commitCti_i);
      updateValid_o <= commitCti_i;
      if (commitCti_i) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commitCti_i) begin
      update_o <= mem[head];
    end
  end

  assign tailTag_o = tail;
  // Stall fetch unless a whole bundle of control slots can fit
  assign full_o    = count > ctiCntT'(CTIQ_DEPTH - FETCH_WIDTH);

  commitNotEmpty: assert property (@(posedge clk) disable iff (!rstN_i)
    commitCti_i |-> count != '0);

endmodule

/* fetchBuffer.sv */
`timescale 1ns/1ps

module fetchBuffer
  import fetchPkg::*;
(
  input  logic   clk,
  input  logic   rstN_i,
  input  logic   pushValid_i,
  input  bundleS pushBundle_i,
  input  logic   popReq_i,
  output logic   headValid_o,
  output bundleS headBundle_o,
  output logic   creditReturn_o
);

  bundleS mem [BUF_DEPTH];
  bufPtrT wrPtr;
  bufPtrT rdPtr;
  bufCntT count;
  logic   pop;

  assign headValid_o  = (count != '0);
  assign headBundle_o = mem[rdPtr];
  assign pop          = popReq_i & headValid_o;

  always_ff @(posedge clk) begin
    if (pushValid_i) begin
      mem[wrPtr] <= pushBundle_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      wrPtr          <= '0;
      rdPtr          <= '0;
      count          <= '0;
      creditReturn_o <= 1'b0;
    end else begin
      count          <= count + bufCntT'(pushValid_i) - bufCntT'(pop);
      // One credit goes back per freed entry, a cycle after the pop
      creditReturn_o <= pop;
      if (pushValid_i) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  noOverflow: assert property (@(posedge clk) disable iff (!rstN_i)
    pushValid_i |-> count < bufCntT'(BUF_DEPTH));

endmodule

/* fetchPkg.sv */
package fetchPkg;

  localparam int FETCH_WIDTH = 4;
  localparam int SLOT_STRIDE = 8;
  localparam int BUF_DEPTH   = 4;
  localparam int CTIQ_DEPTH  = 16;

  typedef logic [31:0] pcT;
  typedef logic [63:0] instT;
  typedef logic [$clog2(CTIQ_DEPTH)-1:0]   ctiTagT;
  typedef logic [$clog2(CTIQ_DEPTH+1)-1:0] ctiCntT;
  typedef logic [$clog2(BUF_DEPTH)-1:0]    bufPtrT;
  typedef logic [$clog2(BUF_DEPTH+1)-1:0]  bufCntT;
  typedef logic [$clog2(FETCH_WIDTH)-1:0]  slotIdxT;

  // Only a conditional branch follows the direction prediction
  typedef enum logic [1:0] {
    CT_RETURN = 2'b00,
    CT_CALL   = 2'b01,
    CT_JUMP   = 2'b10,
    CT_BRANCH = 2'b11
  } ctrlTypeE;

  localparam logic [7:0] OP_JUMP   = 8'h01;
  localparam logic [7:0] OP_CALL   = 8'h02;
  localparam logic [7:0] OP_RETURN = 8'h03;
  localparam logic [7:0] OP_BRANCH = 8'h05;

  typedef struct packed {
    instT   instruction;
    pcT     pc;
    pcT     target;
    ctiTagT ctiTag;
    logic   prediction;
    logic   isCtrl;
  } slotPktS;

  typedef struct packed {
    slotPktS [FETCH_WIDTH-1:0] slot;
    logic    [FETCH_WIDTH-1:0] valid;
  } bundleS;

  typedef struct packed {
    pcT   target;
    logic isReturn;
    logic isCall;
    pcT   callPc;
  } redirectS;

  typedef struct packed {
    pcT       pc;
    pcT       target;
    ctrlTypeE ctrlType;
    logic     dir;
  } updateS;

endpackage

/* fetchStage2.sv */
`timescale 1ns/1ps

module fetchStage2
  import fetchPkg::*;
(
  input  logic                       clk,
  input  logic                       rstN_i,
  input  logic                       fetchValid_i,
  input  pcT                         basePc_i,
  input  instT     [FETCH_WIDTH-1:0] bundleWords_i,
  input  logic     [FETCH_WIDTH-1:0] btbHit_i,
  input  pcT       [FETCH_WIDTH-1:0] btbTarget_i,
  input  logic     [FETCH_WIDTH-1:0] prediction_i,
  input  pcT                         rasTop_i,
  output logic                       fetchReady_o,
  output logic                       redirectValid_o,
  output redirectS                   redirect_o,
  output logic                       pushValid_o,
  output bundleS                     pushBundle_o,
  input  logic                       creditReturn_i,
  output logic     [FETCH_WIDTH-1:0] allocMask_o,
  output pcT       [FETCH_WIDTH-1:0] allocPc_o,
  output ctrlTypeE [FETCH_WIDTH-1:0] allocType_o,
  output pcT       [FETCH_WIDTH-1:0] allocTarget_o,
  output logic     [FETCH_WIDTH-1:0] allocDir_o,
  input  ctiTagT                     tailTag_i,
  input  logic                       full_i
);

  pcT       [FETCH_WIDTH-1:0] slotPc;
  logic     [FETCH_WIDTH-1:0] isCtrl;
  ctrlTypeE [FETCH_WIDTH-1:0] ctrlType;
  pcT       [FETCH_WIDTH-1:0] decTarget;
  logic     [FETCH_WIDTH-1:0] takesFlow;
  logic     [FETCH_WIDTH-1:0] validMask;
  logic     [FETCH_WIDTH-1:0] ctrlMask;
  ctiTagT   [FETCH_WIDTH-1:0] slotTag;
  logic                       redirFound;
  logic                       redirMiss;
  redirectS                   redirect;
  bufCntT                     credits;
  logic                       accept;

  for (genvar g = 0; g < FETCH_WIDTH; g++) begin : genSlot
    assign slotPc[g] = basePc_i + pcT'(g * SLOT_STRIDE);

    preDecode uPreDecode (
      .pc_i         (slotPc[g]),
      .instruction_i(bundleWords_i[g]),
      .rasTop_i     (rasTop_i),
      .isCtrl_o     (isCtrl[g]),
      .ctrlType_o   (ctrlType[g]),
      .target_o     (decTarget[g])
    );

    // Everything but a not-taken branch leaves the sequential path
    assign takesFlow[g] = isCtrl[g] & ((ctrlType[g] != CT_BRANCH) | prediction_i[g]);
  end

  // Keep slots up to and including the first redirecting one
  always_comb begin
    redirFound = 1'b0;
    redirMiss  = 1'b0;
    redirect   = '0;
    validMask  = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (!redirFound) begin
        validMask[i] = 1'b1;
        if (takesFlow[i]) begin
          redirFound        = 1'b1;
          redirMiss         = ~btbHit_i[i];
          redirect.target   = decTarget[i];
          redirect.isReturn = (ctrlType[i] == CT_RETURN);
          redirect.isCall   = (ctrlType[i] == CT_CALL);
          redirect.callPc   = slotPc[i];
        end
      end
    end
  end

  assign ctrlMask = validMask & isCtrl;

  always_comb begin : tagAssign
    ctiTagT nextTag;
    nextTag = tailTag_i;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      slotTag[i] = '0;
      if (ctrlMask[i]) begin
        slotTag[i] = nextTag;
        nextTag    = nextTag + 1'b1;
      end
    end
  end

  always_comb begin
    pushBundle_o.valid = validMask;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      pushBundle_o.slot[i].instruction = bundleWords_i[i];
      pushBundle_o.slot[i].pc          = slotPc[i];
      pushBundle_o.slot[i].target      = isCtrl[i] ? decTarget[i] : btbTarget_i[i];
      pushBundle_o.slot[i].ctiTag      = slotTag[i];
      pushBundle_o.slot[i].prediction  = prediction_i[i];
      pushBundle_o.slot[i].isCtrl      = isCtrl[i];
    end
  end

  assign fetchReady_o    = (credits != '0) & ~full_i;
  assign accept          = fetchValid_i & fetchReady_o;
  assign pushValid_o     = accept;
  assign redirectValid_o = accept & redirMiss;
  assign redirect_o      = redirect;

  assign allocMask_o   = accept ? ctrlMask : '0;
  assign allocPc_o     = slotPc;
  assign allocType_o   = ctrlType;
  assign allocTarget_o = decTarget;
  assign allocDir_o    = takesFlow;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      credits <= bufCntT'(BUF_DEPTH);
    end else begin
      case ({creditReturn_i, accept})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
    end
  end

  creditBound: assert property (@(posedge clk) disable iff (!rstN_i)
    credits <= bufCntT'(BUF_DEPTH));

endmodule

/* fetchTop.sv */
`timescale 1ns/1ps

module fetchTop
  import fetchPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN_i,
  input  logic                   fetchValid_i,
  input  pcT                     basePc_i,
  input  instT [FETCH_WIDTH-1:0] bundleWords_i,
  input  logic [FETCH_WIDTH-1:0] btbHit_i,
  input  pcT   [FETCH_WIDTH-1:0] btbTarget_i,
  input  logic [FETCH_WIDTH-1:0] prediction_i,
  input  pcT                     rasTop_i,
  output logic                   fetchReady_o,
  output logic                   redirectValid_o,
  output redirectS               redirect_o,
  input  logic                   commitCti_i,
  output logic                   updateValid_o,
  output updateS                 updateS_o,
  input  logic                   decodeReady_i,
  output logic                   instValid_o,
  output slotPktS                instPkt_o
);

  logic                       pushValid;
  bundleS                     pushBundle;
  logic                       creditReturn;
  logic                       headValid;
  bundleS                     headBundle;
  logic                       popReq;
  logic     [FETCH_WIDTH-1:0] allocMask;
  pcT       [FETCH_WIDTH-1:0] allocPc;
  ctrlTypeE [FETCH_WIDTH-1:0] allocType;
  pcT       [FETCH_WIDTH-1:0] allocTarget;
  logic     [FETCH_WIDTH-1:0] allocDir;
  ctiTagT                     tailTag;
  logic                       ctiFull;

  fetchStage2 uFetchStage2 (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .fetchValid_i   (fetchValid_i),
    .basePc_i       (basePc_i),
    .bundleWords_i  (bundleWords_i),
    .btbHit_i       (btbHit_i),
    .btbTarget_i    (btbTarget_i),
    .prediction_i   (prediction_i),
    .rasTop_i       (rasTop_i),
    .fetchReady_o   (fetchReady_o),
    .redirectValid_o(redirectValid_o),
    .redirect_o     (redirect_o),
    .pushValid_o    (pushValid),
    .pushBundle_o   (pushBundle),
    .creditReturn_i (creditReturn),
    .allocMask_o    (allocMask),
    .allocPc_o      (allocPc),
    .allocType_o    (allocType),
    .allocTarget_o  (allocTarget),
    .allocDir_o     (allocDir),
    .tailTag_i      (tailTag),
    .full_i         (ctiFull)
  );

  ctiQueue uCtiQueue (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .allocMask_i  (allocMask),
    .allocPc_i    (allocPc),
    .allocType_i  (allocType),
    .allocTarget_i(allocTarget),
    .allocDir_i   (allocDir),
    .commitCti_i  (commitCti_i),
    .tailTag_o    (tailTag),
    .full_o       (ctiFull),
    .updateValid_o(updateValid_o),
    .update_o     (updateS_o)
  );

  fetchBuffer uFetchBuffer (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .pushValid_i   (pushValid),
    .pushBundle_i  (pushBundle),
    .popReq_i      (popReq),
    .headValid_o   (headValid),
    .headBundle_o  (headBundle),
    .creditReturn_o(creditReturn)
  );

  instSerializer uInstSerializer (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .headValid_i  (headValid),
    .headBundle_i (headBundle),
    .decodeReady_i(decodeReady_i),
    .popReq_o     (popReq),
    .instValid_o  (instValid_o),
    .instPkt_o    (instPkt_o)
  );

endmodule

/* instSerializer.sv */
`timescale 1ns/1ps

module instSerializer
  import fetchPkg::*;
(
  input  logic    clk,
  input  logic    rstN_i,
  input  logic    headValid_i,
  input  bundleS  headBundle_i,
  input  logic    decodeReady_i,
  output logic    popReq_o,
  output logic    instValid_o,
  output slotPktS instPkt_o
);

  slotIdxT slotPtr;
  slotIdxT curIdx;
  logic    slotFound;
  logic    moreAfter;
  logic    fire;

  // First valid slot at or after the pointer, and whether any follow it
  always_comb begin
    curIdx    = slotPtr;
    slotFound = 1'b0;
    moreAfter = 1'b0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (i >= int'(slotPtr) && headBundle_i.valid[i]) begin
        if (!slotFound) begin
          curIdx    = slotIdxT'(i);
          slotFound = 1'b1;
        end else begin
          moreAfter = 1'b1;
        end
      end
    end
  end

  assign instValid_o = headValid_i & slotFound;
  assign instPkt_o   = headBundle_i.slot[curIdx];
  assign fire        = instValid_o & decodeReady_i;
  assign popReq_o    = fire & ~moreAfter;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      slotPtr <= '0;
    end else if (fire) begin
      slotPtr <= moreAfter ? curIdx + 1'b1 : '0;
    end
  end

  holdUnderStall: assert property (@(posedge clk) disable iff (!rstN_i)
    instValid_o && !decodeReady_i |=> instValid_o && $stable(instPkt_o));

endmodule

/* preDecode.sv */
`timescale 1ns/1ps

module preDecode
  import fetchPkg::*;
(
  input  pcT       pc_i,
  input  instT     instruction_i,
  input  pcT       rasTop_i,
  output logic     isCtrl_o,
  output ctrlTypeE ctrlType_o,
  output pcT       target_o
);

  logic [7:0]  opcode;
  logic [15:0] offset;
  pcT          offsetBytes;
  pcT          directTarget;

  assign opcode = instruction_i[7:0];
  assign offset = instruction_i[23:8];

  // Word offset counts slots, relative to the next sequential slot
  assign offsetBytes  = {{16{offset[15]}}, offset} * pcT'(SLOT_STRIDE);
  assign directTarget = pc_i + pcT'(SLOT_STRIDE) + offsetBytes;

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CT_JUMP;
    case (opcode)
      OP_RETURN: ctrlType_o = CT_RETURN;
      OP_CALL:   ctrlType_o = CT_CALL;
      OP_JUMP:   ctrlType_o = CT_JUMP;
      OP_BRANCH: ctrlType_o = CT_BRANCH;
      default:   isCtrl_o = 1'b0;
    endcase
  end

  // Return address comes from the stack top, not the instruction
  assign target_o = (isCtrl_o && ctrlType_o == CT_RETURN) ? rasTop_i : directTarget;

endmodule

/* tbFetchTop.sv */
`timescale 1ns/1ps

module tbFetchTop
  import fetchPkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_BUNDLES     = 300;
  localparam int WATCHDOG_CYCLES = NUM_BUNDLES * 20 + 200;
  localparam int CMP_W           = 160;

  typedef logic [CMP_W-1:0] cmpT;

  logic                   clk;
  logic                   rstN;
  logic                   fetchValid;
  pcT                     basePc;
  instT [FETCH_WIDTH-1:0] bundleWords;
  logic [FETCH_WIDTH-1:0] btbHit;
  pcT   [FETCH_WIDTH-1:0] btbTarget;
  logic [FETCH_WIDTH-1:0] prediction;
  pcT                     rasTop;
  logic                   fetchReady;
  logic                   redirectValid;
  redirectS               redirect;
  logic                   commitCti;
  logic                   updateValid;
  updateS                 update;
  logic                   decodeReady;
  logic                   instValid;
  slotPktS                instPkt;

  integer  seed;
  slotPktS expPkts[$];
  logic    expLast[$];
  updateS  ctiModel[$];
  int      modelTail;
  int      modelCredits;
  logic    creditDue;
  logic    updateDue;
  updateS  updateExp;
  int      accepted;
  logic    draining;

  fetchTop u_dut (
    .clk            (clk),
    .rstN_i         (rstN),
    .fetchValid_i   (fetchValid),
    .basePc_i       (basePc),
    .bundleWords_i  (bundleWords),
    .btbHit_i       (btbHit),
    .btbTarget_i    (btbTarget),
    .prediction_i   (prediction),
    .rasTop_i       (rasTop),
    .fetchReady_o   (fetchReady),
    .redirectValid_o(redirectValid),
    .redirect_o     (redirect),
    .commitCti_i    (commitCti),
    .updateValid_o  (updateValid),
    .updateS_o      (update),
    .decodeReady_i  (decodeReady),
    .instValid_o    (instValid),
    .instPkt_o      (instPkt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic checkEq(input cmpT got, input cmpT exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic driveInputs();
    instT [FETCH_WIDTH-1:0] words;
    logic [FETCH_WIDTH-1:0] hits;
    logic [FETCH_WIDTH-1:0] preds;
    pcT   [FETCH_WIDTH-1:0] targets;
    logic [7:0]             op;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      // Mostly control opcodes so the CTI queue fills up
      case (randBelow(6))
        0:       op = OP_JUMP;
        1:       op = OP_CALL;
        2:       op = OP_RETURN;
        3, 4:    op = OP_BRANCH;
        default: op = 8'($random(seed));
      endcase
      words[i]      = {$random(seed), $random(seed)};
      words[i][7:0] = op;
      hits[i]       = (randBelow(2) == 1);
      preds[i]      = (randBelow(2) == 1);
      targets[i]    = pcT'($random(seed));
    end
    fetchValid  <= !draining && (randBelow(10) < 8);
    basePc      <= pcT'($random(seed)) & ~pcT'(7);
    bundleWords <= words;
    btbHit      <= hits;
    btbTarget   <= targets;
    prediction  <= preds;
    rasTop      <= pcT'($random(seed)) & ~pcT'(7);
    decodeReady <= draining || (randBelow(10) < 7);
    commitCti   <= (ctiModel.size() != 0) && (draining || randBelow(2) == 1);
  endtask

  // Applies the filter, tag and recovery rules to the accepted bundle
  task automatic modelBundle();
    logic       ctrl;
    logic       flows;
    logic       found;
    logic       miss;
    ctrlTypeE   ctype;
    pcT         pc;
    pcT         tgt;
    int         off;
    slotPktS    pkt;
    updateS     ent;
    redirectS   expRedir;
    found    = 1'b0;
    miss     = 1'b0;
    expRedir = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (!found) begin
        pc    = basePc + pcT'(i * SLOT_STRIDE);
        ctrl  = 1'b1;
        ctype = CT_JUMP;
        case (bundleWords[i][7:0])
          OP_RETURN: ctype = CT_RETURN;
          OP_CALL:   ctype = CT_CALL;
          OP_JUMP:   ctype = CT_JUMP;
          OP_BRANCH: ctype = CT_BRANCH;
          default:   ctrl = 1'b0;
        endcase
        off   = $signed(bundleWords[i][23:8]);
        tgt   = (ctrl && ctype == CT_RETURN) ? rasTop : pc + pcT'(SLOT_STRIDE + off * SLOT_STRIDE);
        flows = ctrl && (ctype != CT_BRANCH || prediction[i]);
        pkt.instruction = bundleWords[i];
        pkt.pc          = pc;
        pkt.target      = ctrl ? tgt : btbTarget[i];
        pkt.prediction  = prediction[i];
        pkt.isCtrl      = ctrl;
        pkt.ctiTag      = '0;
        if (ctrl) begin
          pkt.ctiTag   = ctiTagT'(modelTail);
          modelTail    = (modelTail + 1) % CTIQ_DEPTH;
          ent.pc       = pc;
          ent.target   = tgt;
          ent.ctrlType = ctype;
          ent.dir      = flows;
          ctiModel.push_back(ent);
        end
        expPkts.push_back(pkt);
        expLast.push_back(1'b0);
        if (flows) begin
          found             = 1'b1;
          miss              = !btbHit[i];
          expRedir.target   = tgt;
          expRedir.isReturn = (ctype == CT_RETURN);
          expRedir.isCall   = (ctype == CT_CALL);
          expRedir.callPc   = pc;
        end
      end
    end
    expLast[expLast.size() - 1] = 1'b1;
    checkEq(cmpT'(redirectValid), cmpT'(miss), "redirectValid_o on accept");
    if (miss) begin
      checkEq(cmpT'(redirect.target), cmpT'(expRedir.target), "redirect target");
      checkEq(cmpT'(redirect.isReturn), cmpT'(expRedir.isReturn), "redirect isReturn");
      checkEq(cmpT'(redirect.isCall), cmpT'(expRedir.isCall), "redirect isCall");
      checkEq(cmpT'(redirect.callPc), cmpT'(expRedir.callPc), "redirect callPc");
    end
  endtask

  // Sampled at the falling edge, where all DUT outputs are settled
  task automatic checkCycle();
    logic    accept;
    logic    popNow;
    logic    expReady;
    slotPktS exp;
    checkEq(cmpT'(updateValid), cmpT'(updateDue), "updateValid_o");
    if (updateDue) begin
      checkEq(cmpT'(update), cmpT'(updateExp), "updateS_o");
    end
    updateDue = 1'b0;

    expReady = (modelCredits != 0) && (ctiModel.size() <= CTIQ_DEPTH - FETCH_WIDTH);
    checkEq(cmpT'(fetchReady), cmpT'(expReady), "fetchReady_o");
    accept = fetchValid && fetchReady;

    popNow = 1'b0;
    checkEq(cmpT'(instValid), cmpT'(expPkts.size() != 0), "instValid_o");
    if (instValid) begin
      exp = expPkts[0];
      checkEq(cmpT'(instPkt.instruction), cmpT'(exp.instruction), "instruction");
      checkEq(cmpT'(instPkt.pc), cmpT'(exp.pc), "pc");
      checkEq(cmpT'(instPkt.prediction), cmpT'(exp.prediction), "prediction");
      checkEq(cmpT'(instPkt.isCtrl), cmpT'(exp.isCtrl), "isCtrl");
      checkEq(cmpT'(instPkt.target), cmpT'(exp.target), "target");
      checkEq(cmpT'(instPkt.ctiTag), cmpT'(exp.ctiTag), "ctiTag");
      if (decodeReady) begin
        popNow = expLast[0];
        void'(expPkts.pop_front());
        void'(expLast.pop_front());
      end
    end

    if (commitCti) begin
      updateExp = ctiModel.pop_front();
      updateDue = 1'b1;
    end

    if (accept) begin
      modelBundle();
      accepted++;
    end else begin
      checkEq(cmpT'(redirectValid), cmpT'(0), "redirectValid_o without accept");
    end

    // Credit comes back a cycle after the buffer pop
    modelCredits = modelCredits - int'(accept) + int'(creditDue);
    creditDue    = popNow;
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed         = 32'h8394373e;
    rstN         = 1'b0;
    fetchValid   = 1'b0;
    basePc       = '0;
    bundleWords  = '0;
    btbHit       = '0;
    btbTarget    = '0;
    prediction   = '0;
    rasTop       = '0;
    commitCti    = 1'b0;
    decodeReady  = 1'b0;
    modelTail    = 0;
    modelCredits = BUF_DEPTH;
    creditDue    = 1'b0;
    updateDue    = 1'b0;
    updateExp    = '0;
    accepted     = 0;
    draining     = 1'b0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    while (!(draining && expPkts.size() == 0 && ctiModel.size() == 0 && !updateDue)) begin
      @(posedge clk);
      driveInputs();
      @(negedge clk);
      checkCycle();
      if (accepted >= NUM_BUNDLES) begin
        draining = 1'b1;
      end
    end

    $display("Accepted %0d bundles", accepted);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* verilog.f */
fetchPkg.sv
preDecode.sv
ctiQueue.sv
fetchStage2.sv
fetchBuffer.sv
instSerializer.sv
fetchTop.sv
tbFetchTop.sv
